//--- vlog.f
hw/dmmu_pkg.sv
hw/tlb_spr_if.sv
hw/dmmu_spr_port.sv
hw/dmmu_tlb_ram.sv
hw/dmmu_tlb_lookup.sv
hw/dmmu_access_check.sv
hw/dmmu_top.sv
sim/tb_clock_gen.sv
sim/dmmu_checker.sv
sim/tb_dmmu.sv

//--- Makefile
SIM := obj_dir/Vtb_dmmu

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing --top-module tb_dmmu -f vlog.f -Mdir obj_dir -o Vtb_dmmu

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_dmmu.sv
// Testbench top: random SPR and lookup traffic into the data TLB, checked by dmmu_checker
`timescale 1ns/10ps

module tb_dmmu;
   import dmmu_pkg::*;

   localparam int INIT_SETS = 8;
   localparam int NUM_OPS   = 500;
   localparam int TOTAL_OPS = 2 * INIT_SETS + NUM_OPS;
   localparam int ACK_LIMIT = 4;

   logic                  clk;
   logic                  rst;
   logic [ADDR_W-1:0]     virt_addr = '0;
   logic                  op_load = 1'b0;
   logic                  op_store = 1'b0;
   logic                  supervisor = 1'b0;
   logic [ADDR_W-1:0]     phys_addr;
   logic                  cache_inhibit;
   logic                  tlb_miss;
   logic                  pagefault;
   logic [SPR_ADDR_W-1:0] spr_addr = '0;
   logic                  spr_we = 1'b0;
   logic                  spr_stb = 1'b0;
   logic [ADDR_W-1:0]     spr_wdata = '0;
   logic [ADDR_W-1:0]     spr_rdata;
   logic                  spr_ack;
   logic [31:0]           rng_state = 32'h6700;
   int                    handshake_errors = 0;
   int                    errors;
   int                    checks;

   tb_clock_gen u_clock (.clk(clk), .rst(rst));

   dmmu_top UUT (
      .clk (clk), .rst (rst),
      .virt_addr_i (virt_addr), .op_load_i (op_load), .op_store_i (op_store),
      .supervisor_mode_i (supervisor), .phys_addr_o (phys_addr),
      .cache_inhibit_o (cache_inhibit), .tlb_miss_o (tlb_miss), .pagefault_o (pagefault),
      .spr_bus_addr_i (spr_addr), .spr_bus_we_i (spr_we), .spr_bus_stb_i (spr_stb),
      .spr_bus_dat_i (spr_wdata), .spr_bus_dat_o (spr_rdata), .spr_bus_ack_o (spr_ack)
   );

   dmmu_checker u_checker (
      .clk (clk), .rst (rst),
      .virt_addr_i (virt_addr), .op_load_i (op_load), .op_store_i (op_store),
      .supervisor_mode_i (supervisor), .phys_addr_i (phys_addr),
      .cache_inhibit_i (cache_inhibit), .tlb_miss_i (tlb_miss), .pagefault_i (pagefault),
      .spr_addr_i (spr_addr), .spr_we_i (spr_we), .spr_stb_i (spr_stb),
      .spr_wdata_i (spr_wdata), .spr_rdata_i (spr_rdata), .spr_ack_i (spr_ack),
      .errors_o (errors), .checks_o (checks)
   );

   // Upper halves of two LCG steps, the low bits have short periods
   function automatic logic [31:0] next_random();
      logic [15:0] first_half;
      rng_state  = rng_state * 32'd1664525 + 32'd1013904223;
      first_half = rng_state[31:16];
      rng_state  = rng_state * 32'd1664525 + 32'd1013904223;
      return {first_half, rng_state[31:16]};
   endfunction

   // Two VPN tops only, so hits are common
   function automatic logic [12:0] vpn_high(input logic pick);
      return pick ? 13'h0A5C : 13'h1F03;
   endfunction

   function automatic logic [SPR_ADDR_W-1:0] array_addr(input logic trans, input set_idx_t idx);
      logic [31:0] r;
      r = next_random();
      return {5'd1, (r[1:0] == 2'b00) ? 2'b01 : r[1:0], r[2], trans, r[3], idx};
   endfunction

   // Valid three times out of four
   function automatic logic [ADDR_W-1:0] match_entry(input set_idx_t idx);
      logic [31:0] r;
      r = next_random();
      return {vpn_high(r[0]), idx, r[13:2], r[15:14] != 2'b00};
   endfunction

   task automatic spr_access(input logic [SPR_ADDR_W-1:0] addr, input logic we,
                             input logic [ADDR_W-1:0] data, input logic expect_ack);
      int waited;
      waited    = 0;
      op_load   = 1'b0;
      op_store  = 1'b0;
      spr_addr  = addr;
      spr_we    = we;
      spr_wdata = data;
      spr_stb   = 1'b1;
      @(negedge clk);
      while (!spr_ack && waited < ACK_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      if (expect_ack && !spr_ack) begin
         handshake_errors++;
         $display("No acknowledge came for SPR address %h at %0t", addr, $time);
      end
      spr_stb = 1'b0;
      spr_we  = 1'b0;
   endtask

   task automatic issue_lookup(input logic [ADDR_W-1:0] addr, input logic load,
                               input logic store, input logic sup);
      virt_addr  = addr;
      op_load    = load;
      op_store   = store;
      supervisor = sup;
      @(negedge clk);
      op_load  = 1'b0;
      op_store = 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      set_idx_t    set_sel;
      logic [4:0]  group;
      wait (!rst);
      @(negedge clk);
      for (int s = 0; s < INIT_SETS; s++) begin
         spr_access(array_addr(1'b0, set_idx_t'(s)), 1'b1, match_entry(set_idx_t'(s)), 1'b1);
         spr_access(array_addr(1'b1, set_idx_t'(s)), 1'b1, next_random(), 1'b1);
      end
      for (int n = 0; n < NUM_OPS; n++) begin
         r       = next_random();
         set_sel = {3'b000, r[10:8]};
         group   = (r[16:12] == 5'd1) ? 5'd3 : r[16:12];
         case (r[2:0])
            3'd5: spr_access(array_addr(r[3], set_sel), 1'b0, '0, 1'b1);
            3'd6: begin
               if (r[3]) begin
                  spr_access(array_addr(1'b1, set_sel), 1'b1, next_random(), 1'b1);
               end else begin
                  spr_access(array_addr(1'b0, set_sel), 1'b1, match_entry(set_sel), 1'b1);
               end
            end
            3'd7: begin
               // Group 1 outside the arrays, or another group that never acks
               if (r[11]) begin
                  spr_access({5'd1, 2'b00, r[20:12]}, r[21], next_random(), 1'b1);
               end else begin
                  spr_access({group, r[27:17]}, r[28], next_random(), 1'b0);
               end
            end
            default: issue_lookup({vpn_high(r[4]), set_sel, r[31:19]}, r[5], r[6], r[7]);
         endcase
      end
      repeat (3) @(negedge clk);
      if (checks == 0) begin
         $display("No DUT response was ever compared");
      end
      $display("Checks: %0d, value errors: %0d, handshake errors: %0d",
               checks, errors, handshake_errors);
      if (errors == 0 && handshake_errors == 0 && checks > 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Ten cycles per operation at most
   initial begin
      #(TOTAL_OPS * 10 * 8);
      $display("Watchdog expired before all %0d operations finished", TOTAL_OPS);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- sim/dmmu_checker.sv
// Testbench checker that keeps a shadow TLB from observed SPR writes and compares every DUT response
`timescale 1ns/10ps

module dmmu_checker (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [dmmu_pkg::ADDR_W-1:0]     virt_addr_i,
   input  logic                            op_load_i,
   input  logic                            op_store_i,
   input  logic                            supervisor_mode_i,
   input  logic [dmmu_pkg::ADDR_W-1:0]     phys_addr_i,
   input  logic                            cache_inhibit_i,
   input  logic                            tlb_miss_i,
   input  logic                            pagefault_i,
   input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic                            spr_we_i,
   input  logic                            spr_stb_i,
   input  logic [dmmu_pkg::ADDR_W-1:0]     spr_wdata_i,
   input  logic [dmmu_pkg::ADDR_W-1:0]     spr_rdata_i,
   input  logic                            spr_ack_i,
   output int                              errors_o,
   output int                              checks_o
);
   import dmmu_pkg::*;

   logic [ADDR_W-1:0] match_mem [2**SET_W];
   logic [ADDR_W-1:0] trans_mem [2**SET_W];
   logic              match_known [2**SET_W] = '{default: 1'b0};
   logic              trans_known [2**SET_W] = '{default: 1'b0};
   int                errors = 0;
   int                checks = 0;

   // Expected outputs for the cycle after the last clock edge
   logic              ack_armed = 1'b0;
   logic              rdata_known = 1'b0;
   logic [ADDR_W-1:0] exp_rdata = '0;
   logic              lookup_due = 1'b0;
   string             kind = "";
   logic              exp_miss;
   logic [ADDR_W-1:0] exp_phys;
   logic              exp_ci;
   logic              exp_fault;

   assign errors_o = errors;
   assign checks_o = checks;

   task automatic check_value(input string name, input logic [ADDR_W-1:0] expected,
                              input logic [ADDR_W-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic evaluate_cycle();
      logic              group_hit;
      logic              array_hit;
      set_idx_t          spr_set;
      set_idx_t          virt_set;
      logic [ADDR_W-1:0] match_entry;
      logic [ADDR_W-1:0] trans_entry;
      logic              hit;
      logic              read_ok;
      logic              write_ok;

      group_hit = spr_addr_i[15:11] == 5'd1;
      array_hit = spr_stb_i && group_hit && spr_addr_i[10:9] != 2'b00 && !rst;
      spr_set   = spr_addr_i[5:0];
      virt_set  = virt_addr_i[18:13];

      // Ack one cycle after a group 1 strobe that is still held
      ack_armed = spr_stb_i && group_hit && !rst;

      // Entry as it was before this cycle's write
      exp_rdata   = '0;
      rdata_known = 1'b1;
      if (array_hit && spr_addr_i[7]) begin
         exp_rdata   = trans_mem[spr_set];
         rdata_known = trans_known[spr_set];
      end else if (array_hit) begin
         exp_rdata   = match_mem[spr_set];
         rdata_known = match_known[spr_set];
      end

      lookup_due = 1'b0;
      if (array_hit && (op_load_i || op_store_i)) begin
         errors++;
         $display("A lookup was issued while an SPR access held the arrays at %0t", $time);
      end else if (!array_hit && !rst && match_known[virt_set] && trans_known[virt_set]) begin
         lookup_due  = 1'b1;
         match_entry = match_mem[virt_set];
         trans_entry = trans_mem[virt_set];
         hit = match_entry[0] && match_entry[31:13] == virt_addr_i[31:13];
         if (hit) begin
            kind     = "hit";
            exp_phys = {trans_entry[31:13], virt_addr_i[12:0]};
            read_ok  = supervisor_mode_i ? trans_entry[8] : trans_entry[6];
            write_ok = supervisor_mode_i ? trans_entry[9] : trans_entry[7];
         end else begin
            kind     = "miss";
            exp_phys = {19'd0, virt_addr_i[12:0]};
            read_ok  = 1'b0;
            write_ok = 1'b0;
         end
         exp_miss  = !hit;
         exp_ci    = hit && trans_entry[1];
         exp_fault = (op_load_i && !read_ok) || (op_store_i && !write_ok);
      end

      // Shadow write lands after the read as in the RAM
      if (array_hit && spr_we_i && spr_addr_i[7]) begin
         trans_mem[spr_set]   = spr_wdata_i;
         trans_known[spr_set] = 1'b1;
      end else if (array_hit && spr_we_i) begin
         match_mem[spr_set]   = spr_wdata_i;
         match_known[spr_set] = 1'b1;
      end
   endtask

   task automatic compare_outputs();
      // Ack also needs the strobe and the group as they are now
      check_value("spr_ack",
                  ADDR_W'(ack_armed && spr_stb_i && spr_addr_i[15:11] == 5'd1),
                  ADDR_W'(spr_ack_i));
      if (rdata_known) begin
         check_value("spr_readback", exp_rdata, spr_rdata_i);
      end
      if (lookup_due) begin
         check_value({kind, "_flag"}, ADDR_W'(exp_miss), ADDR_W'(tlb_miss_i));
         check_value({kind, "_phys_addr"}, exp_phys, phys_addr_i);
         check_value({kind, "_cache_inhibit"}, ADDR_W'(exp_ci), ADDR_W'(cache_inhibit_i));
         check_value("permission_fault", ADDR_W'(exp_fault), ADDR_W'(pagefault_i));
      end
   endtask

   // Inputs still hold what the edge sampled
   always @(posedge clk) begin
      #1;
      evaluate_cycle();
      compare_outputs();
   end

   // Registered outputs must hold while the next inputs are already driven
   always @(negedge clk) begin
      #1;
      compare_outputs();
   end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source, 8 ns period with reset held for the first 4 cycles
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);
   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 4;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Released on a falling edge, same as the other DUT inputs
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

//--- hw/dmmu_top.sv
// Data TLB top level with plain lookup and SPR bus ports
`timescale 1ns/10ps

module dmmu_top (
   input  logic                            clk,
   input  logic                            rst,

   // Lookup request, result one cycle later
   input  logic [dmmu_pkg::ADDR_W-1:0]     virt_addr_i,
   input  logic                            op_load_i,
   input  logic                            op_store_i,
   input  logic                            supervisor_mode_i,
   output logic [dmmu_pkg::ADDR_W-1:0]     phys_addr_o,
   output logic                            cache_inhibit_o,
   output logic                            tlb_miss_o,
   output logic                            pagefault_o,

   // SPR bus
   input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_bus_addr_i,
   input  logic                            spr_bus_we_i,
   input  logic                            spr_bus_stb_i,
   input  logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_i,
   output logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_o,
   output logic                            spr_bus_ack_o
);
   import dmmu_pkg::*;

   lookup_result_t lookup_result;

   tlb_spr_if u_spr_if ();

   dmmu_spr_port u_spr_port (
      .clk            (clk),
      .rst            (rst),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .spr_bus_dat_o  (spr_bus_dat_o),
      .spr_bus_ack_o  (spr_bus_ack_o),
      .spr            (u_spr_if.port)
   );

   dmmu_tlb_lookup u_lookup (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (virt_addr_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .supervisor_mode_i (supervisor_mode_i),
      .spr               (u_spr_if.tlb),
      .result_o          (lookup_result)
   );

   dmmu_access_check u_check (
      .result_i        (lookup_result),
      .phys_addr_o     (phys_addr_o),
      .cache_inhibit_o (cache_inhibit_o),
      .tlb_miss_o      (tlb_miss_o),
      .pagefault_o     (pagefault_o)
   );

endmodule

//--- hw/dmmu_access_check.sv
// Turns a lookup result into physical address, cache inhibit, miss and page fault
`timescale 1ns/10ps

module dmmu_access_check (
   input  dmmu_pkg::lookup_result_t    result_i,
   output logic [dmmu_pkg::ADDR_W-1:0] phys_addr_o,
   output logic                        cache_inhibit_o,
   output logic                        tlb_miss_o,
   output logic                        pagefault_o
);
   import dmmu_pkg::*;

   logic ure;
   logic uwe;
   logic sre;
   logic swe;
   logic read_ok;
   logic write_ok;

   always_comb begin
      if (result_i.hit) begin
         phys_addr_o     = {result_i.ppn, result_i.offset};
         cache_inhibit_o = result_i.ci;
         ure             = result_i.ure;
         uwe             = result_i.uwe;
         sre             = result_i.sre;
         swe             = result_i.swe;
      end else begin
         // Untranslated offset, nothing permitted
         phys_addr_o     = {{VPN_W{1'b0}}, result_i.offset};
         cache_inhibit_o = 1'b0;
         ure             = 1'b0;
         uwe             = 1'b0;
         sre             = 1'b0;
         swe             = 1'b0;
      end
   end

   assign tlb_miss_o = ~result_i.hit;

   // Supervisor pair in supervisor mode, else user pair
   assign read_ok  = result_i.supervisor ? sre : ure;
   assign write_ok = result_i.supervisor ? swe : uwe;

   // A miss with an op faults as well
   assign pagefault_o = (result_i.load & ~read_ok) | (result_i.store & ~write_ok);

endmodule

//--- hw/dmmu_tlb_lookup.sv
// Match and translate arrays with shared index mux, VPN compare and registered lookup result
`timescale 1ns/10ps

module dmmu_tlb_lookup (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [dmmu_pkg::ADDR_W-1:0] virt_addr_i,
   input  logic                        op_load_i,
   input  logic                        op_store_i,
   input  logic                        supervisor_mode_i,
   tlb_spr_if.tlb                      spr,
   output dmmu_pkg::lookup_result_t    result_o
);
   import dmmu_pkg::*;

   set_idx_t             virt_set;
   set_idx_t             ram_index;
   logic                 spr_active;
   logic                 match_we;
   logic                 trans_we;
   logic [ADDR_W-1:0]    match_entry;
   logic [ADDR_W-1:0]    trans_entry;
   page_num_t            vpn_q;
   logic [PAGE_BITS-1:0] offset_q;
   logic                 load_q;
   logic                 store_q;
   logic                 super_q;

   assign virt_set = virt_addr_i[PAGE_BITS +: SET_W];

   // SPR access owns the arrays for its cycle
   assign spr_active = spr.sel != SEL_NONE;
   assign ram_index  = spr_active ? spr.index : virt_set;
   assign match_we   = (spr.sel == SEL_MATCH) & spr.we;
   assign trans_we   = (spr.sel == SEL_TRANS) & spr.we;

   dmmu_tlb_ram u_match (
      .clk     (clk),
      .index_i (ram_index),
      .we_i    (match_we),
      .wdata_i (spr.wdata),
      .rdata_o (match_entry)
   );

   dmmu_tlb_ram u_trans (
      .clk     (clk),
      .index_i (ram_index),
      .we_i    (trans_we),
      .wdata_i (spr.wdata),
      .rdata_o (trans_entry)
   );

   assign spr.match_rdata = match_entry;
   assign spr.trans_rdata = trans_entry;

   // Address parts line up with the RAM read
   always_ff @(posedge clk) begin
      vpn_q    <= virt_addr_i[ADDR_W-1:PAGE_BITS];
      offset_q <= virt_addr_i[PAGE_BITS-1:0];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         load_q  <= 1'b0;
         store_q <= 1'b0;
         super_q <= 1'b0;
      end else begin
         load_q  <= op_load_i;
         store_q <= op_store_i;
         super_q <= supervisor_mode_i;
      end
   end

   always_comb begin
      result_o.hit        = (match_entry[ADDR_W-1:PAGE_BITS] == vpn_q) &
                            match_entry[MATCH_VALID_BIT];
      result_o.ppn        = trans_entry[ADDR_W-1:PAGE_BITS];
      result_o.offset     = offset_q;
      result_o.ure        = trans_entry[TRANS_URE_BIT];
      result_o.uwe        = trans_entry[TRANS_UWE_BIT];
      result_o.sre        = trans_entry[TRANS_SRE_BIT];
      result_o.swe        = trans_entry[TRANS_SWE_BIT];
      result_o.ci         = trans_entry[TRANS_CI_BIT];
      result_o.load       = load_q;
      result_o.store      = store_q;
      result_o.supervisor = super_q;
   end

endmodule

//--- hw/dmmu_tlb_ram.sv
// Single-port synchronous RAM for one TLB array, instantiated once per array
`timescale 1ns/10ps

module dmmu_tlb_ram (
   input  logic                        clk,
   input  dmmu_pkg::set_idx_t          index_i,
   input  logic                        we_i,
   input  logic [dmmu_pkg::ADDR_W-1:0] wdata_i,
   output logic [dmmu_pkg::ADDR_W-1:0] rdata_o
);
   import dmmu_pkg::*;

   logic [ADDR_W-1:0] mem [2**SET_W];

   // Read before write, so a write returns the old entry
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[index_i] <= wdata_i;
      end
      rdata_o <= mem[index_i];
   end

endmodule

//--- hw/dmmu_spr_port.sv
// SPR bus slave for the data TLB: decodes group 1, acknowledges and returns array read data
`timescale 1ns/10ps

module dmmu_spr_port (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_bus_addr_i,
   input  logic                            spr_bus_we_i,
   input  logic                            spr_bus_stb_i,
   input  logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_i,
   output logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_o,
   output logic                            spr_bus_ack_o,
   tlb_spr_if.port                         spr
);
   import dmmu_pkg::*;

   logic     group_hit;
   logic     array_hit;
   spr_sel_e sel;
   spr_sel_e sel_q;
   logic     ack_q;

   // MMU group in the top address bits
   assign group_hit = spr_bus_addr_i[SPR_ADDR_W-1:SPR_GROUP_LSB] == SPR_GROUP;

   // Any nonzero array field reaches the TLB
   assign array_hit = |spr_bus_addr_i[SPR_GROUP_LSB-1:SPR_ARRAY_LSB];

   always_comb begin
      sel = SEL_NONE;
      if (spr_bus_stb_i && group_hit && array_hit) begin
         if (spr_bus_addr_i[SPR_TRANS_BIT]) begin
            sel = SEL_TRANS;
         end else begin
            sel = SEL_MATCH;
         end
      end
   end

   assign spr.sel   = sel;
   assign spr.we    = spr_bus_we_i;
   assign spr.index = spr_bus_addr_i[SET_W-1:0];
   assign spr.wdata = spr_bus_dat_i;

   // Acknowledge and read select follow the strobe by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         sel_q <= SEL_NONE;
      end else begin
         ack_q <= spr_bus_stb_i & group_hit;
         sel_q <= sel;
      end
   end

   // Dropped strobe or a different group kills the ack at once
   assign spr_bus_ack_o = ack_q & spr_bus_stb_i & group_hit;

   always_comb begin
      case (sel_q)
         SEL_MATCH: spr_bus_dat_o = spr.match_rdata;
         SEL_TRANS: spr_bus_dat_o = spr.trans_rdata;
         default:   spr_bus_dat_o = '0;
      endcase
   end

endmodule

//--- hw/tlb_spr_if.sv
// SPR access channel from the SPR decode to the match and translate arrays
`timescale 1ns/10ps

interface tlb_spr_if;
   import dmmu_pkg::*;

   // Driven by the SPR decode, valid in the strobe cycle
   spr_sel_e          sel;
   logic              we;
   set_idx_t          index;
   logic [ADDR_W-1:0] wdata;

   // Array contents, one cycle after the access
   logic [ADDR_W-1:0] match_rdata;
   logic [ADDR_W-1:0] trans_rdata;

   modport port (
      output sel,
      output we,
      output index,
      output wdata,
      input  match_rdata,
      input  trans_rdata
   );

   modport tlb (
      input  sel,
      input  we,
      input  index,
      input  wdata,
      output match_rdata,
      output trans_rdata
   );

endinterface

//--- hw/dmmu_pkg.sv
// Shared widths, SPR map, entry bit positions and types for the data TLB, imported by every block
package dmmu_pkg;

   // Address and page geometry
   localparam int ADDR_W    = 32;
   localparam int SET_W     = 6;
   localparam int PAGE_BITS = 13;
   localparam int VPN_W     = ADDR_W - PAGE_BITS;

   // SPR address map
   localparam int SPR_ADDR_W    = 16;
   localparam int SPR_GROUP_LSB = 11;
   // Bits 10 to 9 pick the TLB arrays inside the group
   localparam int SPR_ARRAY_LSB = 9;
   localparam int SPR_TRANS_BIT = 7;
   localparam logic [SPR_ADDR_W-SPR_GROUP_LSB-1:0] SPR_GROUP = 1;

   // Match entry layout, VPN sits above PAGE_BITS
   localparam int MATCH_VALID_BIT = 0;

   // Translate entry layout, PPN sits above PAGE_BITS
   localparam int TRANS_CI_BIT  = 1;
   localparam int TRANS_URE_BIT = 6;
   localparam int TRANS_UWE_BIT = 7;
   localparam int TRANS_SRE_BIT = 8;
   localparam int TRANS_SWE_BIT = 9;

   typedef logic [SET_W-1:0] set_idx_t;
   typedef logic [VPN_W-1:0] page_num_t;

   // Which TLB array an SPR access targets
   typedef enum logic [1:0] {
      SEL_NONE  = 2'd0,
      SEL_MATCH = 2'd1,
      SEL_TRANS = 2'd2
   } spr_sel_e;

   // Registered outcome of one lookup
   typedef struct packed {
      logic                 hit;
      page_num_t            ppn;
      logic [PAGE_BITS-1:0] offset;
      logic                 ure;
      logic                 uwe;
      logic                 sre;
      logic                 swe;
      logic                 ci;
      logic                 load;
      logic                 store;
      logic                 supervisor;
   } lookup_result_t;

endpackage
